/* files.f */
+incdir+src
src/nn_pkg.sv
src/apb_job_port.sv
src/job_queue.sv
src/scratchpad.sv
src/layer_engine.sv
src/nn_job_top.sv
test/nn_properties.sv
test/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_top -o tb_sim
output=$(./obj_dir/tb_sim)
echo "$output"
if ! grep -qx "Test OK" <<< "$output"; then
  exit 1
fi

/* test/tb_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "nn_settings.svh"

module tb_top;
  import nn_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  // Six tests of up to about 300 elements at two cycles each, APB traffic, wide margin
  localparam int MAX_CYCLES   = 20000;
  localparam int WORDS        = 1 << `NN_ADDR_W;

  localparam logic [`NN_APB_ADDR_W-1:0] A_SRC    = 12'h000;
  localparam logic [`NN_APB_ADDR_W-1:0] A_AUX    = 12'h004;
  localparam logic [`NN_APB_ADDR_W-1:0] A_DST    = 12'h008;
  localparam logic [`NN_APB_ADDR_W-1:0] A_LEN    = 12'h00c;
  localparam logic [`NN_APB_ADDR_W-1:0] A_OP     = 12'h010;
  localparam logic [`NN_APB_ADDR_W-1:0] A_STATUS = 12'h014;

  logic                      clk;
  logic                      rst_l;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [`NN_APB_ADDR_W-1:0] paddr;
  logic [`NN_DATA_W-1:0]     pwdata;
  logic [`NN_DATA_W-1:0]     prdata;
  logic                      pready;
  logic                      pslverr;
  logic                      busy;
  logic                      job_done;

  // Expected scratchpad contents
  logic [`NN_DATA_W-1:0] model [WORDS];
  logic [15:0]           exp_done;
  logic [15:0]           done_pulses;
  int                    checks;
  int                    errors;
  int                    cycles;

  nn_job_top UUT (
    .clk, .rst_l, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr, .busy, .job_done
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  always @(negedge clk) begin
    if (!rst_l) begin
      done_pulses <= '0;
    end else if (job_done) begin
      done_pulses <= done_pulses + 16'd1;
    end
  end

  function automatic logic [`NN_APB_ADDR_W-1:0] mem_addr(input logic [`NN_ADDR_W-1:0] idx);
    return {2'b10, idx, 2'b00};
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Starts at a falling edge and ends at the falling edge after completion
  task automatic apb_xfer(input logic wr, input logic [`NN_APB_ADDR_W-1:0] addr,
                          input logic [31:0] data, output logic [31:0] rdata,
                          output logic err);
    int waits;
    int exp_waits;
    // Only scratchpad reads take a wait state
    exp_waits = (!wr && addr[`NN_APB_ADDR_W-1]) ? 1 : 0;
    waits     = 0;
    psel      = 1'b1;
    penable   = 1'b0;
    pwrite    = wr;
    paddr     = addr;
    pwdata    = data;
    @(negedge clk);
    penable = 1'b1;
    #1;
    while (!pready) begin
      waits++;
      @(negedge clk);
      #1;
    end
    rdata = prdata;
    err   = pslverr;
    compare($sformatf("apb wait states, write %0d, address %h", wr, addr),
            32'(exp_waits), 32'(waits));
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_word(input logic [`NN_APB_ADDR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, addr, data, rdata, err);
    checks++;
    assert (!err) else begin
      errors++;
      $display("Write to address %h was refused with pslverr", addr);
    end
  endtask

  task automatic read_word(input logic [`NN_APB_ADDR_W-1:0] addr, output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, addr, '0, data, err);
  endtask

  task automatic fill_word(input logic [`NN_ADDR_W-1:0] idx, input logic [31:0] data);
    write_word(mem_addr(idx), data);
    model[idx] = data;
  endtask

  task automatic verify_scratchpad(input string name);
    logic [31:0]           rd;
    logic [`NN_ADDR_W-1:0] idx;
    for (int i = 0; i < WORDS; i++) begin
      idx = `NN_ADDR_W'(i);
      read_word(mem_addr(idx), rd);
      compare($sformatf("%s word %0d", name, i), model[idx], rd);
    end
  endtask

  task automatic expect_status(input string name, input logic full);
    logic [31:0] rd;
    read_word(A_STATUS, rd);
    compare($sformatf("%s status", name), {15'd0, full, exp_done}, rd);
  endtask

  task automatic launch(input string name, input logic [2:0] op, input logic expect_err);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, A_OP, {29'd0, op}, rd, err);
    compare($sformatf("%s pslverr", name), {31'd0, expect_err}, {31'd0, err});
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (busy) begin
      @(negedge clk);
    end
  endtask

  // Sequential per-element reference, addresses wrap at the scratchpad size
  task automatic model_job(input job_t job);
    logic [31:0]           x;
    logic [31:0]           a;
    logic [31:0]           sum;
    logic [`NN_ADDR_W-1:0] ofs;
    sum = '0;
    for (int i = 0; i < int'(job.len); i++) begin
      ofs = `NN_ADDR_W'(i);
      x   = model[job.src_base + ofs];
      a   = model[job.aux_base + ofs];
      case (job.op)
        OP_RELU_FW: model[job.dst_base + ofs] = ($signed(x) < 0) ? '0 : x;
        OP_RELU_BW: model[job.dst_base + ofs] = ($signed(a) > 0) ? x : '0;
        default:    sum = sum + x;
      endcase
    end
    if (job.op == OP_BIAS_GRAD) begin
      model[job.dst_base] = sum;
    end
  endtask

  task automatic run_job(input string name, input job_t job);
    write_word(A_SRC, {24'd0, job.src_base});
    write_word(A_AUX, {24'd0, job.aux_base});
    write_word(A_DST, {24'd0, job.dst_base});
    write_word(A_LEN, {23'd0, job.len});
    launch(name, job.op, 1'b0);
    wait_idle();
    model_job(job);
    exp_done = exp_done + 16'd1;
    expect_status(name, 1'b0);
  endtask

  initial begin
    logic [31:0]          val;
    logic [`NN_LEN_W-1:0] len;
    job_t                 job;
    void'($urandom(32'h8f11_a5d3));
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    rst_l    = 1'b0;
    exp_done = '0;
    checks   = 0;
    errors   = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_l = 1'b1;
    @(negedge clk);
    expect_status("reset", 1'b0);

    for (int i = 0; i < WORDS; i++) begin
      fill_word(`NN_ADDR_W'(i), $urandom);
    end
    verify_scratchpad("scratch_roundtrip");

    len = `NN_LEN_W'(1 + $urandom % 100);
    job = '{OP_RELU_FW, 8'd0, 8'd0, 8'd128, len};
    run_job("relu_fw", job);
    verify_scratchpad("relu_fw");

    // Zero forward inputs must block the gradient too
    for (int i = 0; i < 60; i++) begin
      val = $urandom;
      if (i % 8 == 0) begin
        val = '0;
      end
      fill_word(`NN_ADDR_W'(100 + i), val);
    end
    len = `NN_LEN_W'(1 + $urandom % 60);
    job = '{OP_RELU_BW, 8'd0, 8'd100, 8'd190, len};
    run_job("relu_bw", job);
    verify_scratchpad("relu_bw");

    job = '{OP_BIAS_GRAD, 8'd0, 8'd0, 8'd250, 9'd0};
    run_job("bias_grad_len0", job);
    len = `NN_LEN_W'(1 + $urandom % 256);
    job = '{OP_BIAS_GRAD, 8'd0, 8'd0, 8'd251, len};
    run_job("bias_grad", job);
    verify_scratchpad("bias_grad");

    // One job in the engine, four queued, the sixth launch refused
    write_word(A_SRC, 32'd0);
    write_word(A_LEN, 32'd40);
    for (int k = 0; k < 6; k++) begin
      write_word(A_DST, 32'(48 + 40 * k));
      if (k == 5) begin
        expect_status("queue_full", 1'b1);
      end
      launch("queue_full", OP_RELU_FW, k == 5);
    end
    wait_idle();
    for (int k = 0; k < 5; k++) begin
      job = '{OP_RELU_FW, 8'd0, 8'd0, 8'(48 + 40 * k), 9'd40};
      model_job(job);
    end
    exp_done = exp_done + 16'd5;
    expect_status("queue_drain", 1'b0);
    verify_scratchpad("queue_full");

    write_word(A_DST, 32'd30);
    launch("illegal_op", 3'd0, 1'b1);
    launch("illegal_op", 3'd6, 1'b1);
    compare("illegal_op busy", 32'd0, {31'd0, busy});
    verify_scratchpad("illegal_op");
    expect_status("illegal_op", 1'b0);

    compare("job_done_pulses", {16'd0, exp_done}, {16'd0, done_pulses});
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/nn_properties.sv */
`default_nettype none
`timescale 1ns/1ps

module nn_properties (
  input wire logic clk,
  input wire logic rst_l,
  input wire logic psel,
  input wire logic penable,
  input wire logic pready,
  input wire logic pslverr,
  input wire logic busy,
  input wire logic job_done
);

  // Error response only in a completing access phase
  a_pslverr_access: assert property (@(posedge clk) disable iff (!rst_l)
    pslverr |-> psel && penable && pready)
    else $error("pslverr outside a completing access phase");

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_l)
    job_done |=> !job_done)
    else $error("job_done high for two cycles in a row");

  // A finished job was running the cycle before
  a_done_busy: assert property (@(posedge clk) disable iff (!rst_l)
    job_done |-> $past(busy))
    else $error("job_done without busy in the previous cycle");

  a_idle_ready: assert property (@(posedge clk) disable iff (!rst_l)
    !psel |-> pready)
    else $error("pready low while psel is low");

endmodule

bind nn_job_top nn_properties u_props (
  .clk, .rst_l, .psel, .penable, .pready, .pslverr, .busy, .job_done
);

`default_nettype wire

/* src/nn_job_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "nn_settings.svh"

module nn_job_top (
  input  wire logic                      clk,
  input  wire logic                      rst_l,
  input  wire logic                      psel,
  input  wire logic                      penable,
  input  wire logic                      pwrite,
  input  wire logic [`NN_APB_ADDR_W-1:0] paddr,
  input  wire logic [`NN_DATA_W-1:0]     pwdata,
  output logic      [`NN_DATA_W-1:0]     prdata,
  output logic                           pready,
  output logic                           pslverr,
  output logic                           busy,
  output logic                           job_done
);
  import nn_pkg::*;

  job_t                  push_job;
  job_t                  pop_job;
  mem_req_t              host_req;
  mem_req_t              eng_req;
  logic                  push_valid;
  logic                  push_ready;
  logic                  pop_valid;
  logic                  pop_ready;
  logic                  queue_full;
  logic                  queue_empty;
  logic                  host_req_valid;
  logic                  eng_req_valid;
  logic                  eng_active;
  logic [`NN_DATA_W-1:0] host_rdata;
  logic [`NN_DATA_W-1:0] eng_rdata;
  logic [15:0]           done_count;

  apb_job_port u_port (
    .clk, .rst_l, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .push_valid, .push_job, .push_ready,
    .queue_full, .done_count,
    .host_req, .host_req_valid, .host_rdata
  );

  job_queue u_queue (
    .clk, .rst_l, .push_valid, .push_job, .pop_ready,
    .push_ready, .pop_valid, .pop_job,
    .full(queue_full), .empty(queue_empty)
  );

  scratchpad u_mem (
    .clk, .host_req, .host_req_valid, .eng_req, .eng_req_valid,
    .host_rdata, .eng_rdata
  );

  layer_engine u_engine (
    .clk, .rst_l, .pop_valid, .pop_job, .pop_ready,
    .eng_req, .eng_req_valid, .eng_rdata,
    .job_done, .active(eng_active), .done_count
  );

  // Busy covers queued jobs as well as the running one
  assign busy = eng_active || !queue_empty;

endmodule

`default_nettype wire

/* src/layer_engine.sv */
`default_nettype none
`timescale 1ns/1ps

`include "nn_settings.svh"

module layer_engine (
  input  wire logic                  clk,
  input  wire logic                  rst_l,
  input  wire logic                  pop_valid,
  input  wire nn_pkg::job_t          pop_job,
  output logic                       pop_ready,
  output nn_pkg::mem_req_t           eng_req,
  output logic                       eng_req_valid,
  input  wire logic [`NN_DATA_W-1:0] eng_rdata,
  output logic                       job_done,
  output logic                       active,
  output logic [15:0]                done_count
);
  import nn_pkg::*;

  eng_state_e            state;
  job_t                  job;
  logic [`NN_LEN_W-1:0]  idx;
  logic [`NN_LEN_W-1:0]  idx_next;
  logic [`NN_ADDR_W-1:0] ofs;
  logic [`NN_DATA_W-1:0] acc;
  logic [`NN_DATA_W-1:0] relu_out;
  logic                  aux_pos;
  logic                  src_phase;
  logic                  bw_src_read;
  logic                  elem_done;
  logic                  last;
  logic                  finish;

  assign pop_ready = state == IDLE;
  assign active    = state != IDLE;
  assign idx_next  = idx + 1'b1;
  assign last      = idx_next == job.len;
  assign ofs       = idx[`NN_ADDR_W-1:0];
  assign relu_out  = eng_rdata[`NN_DATA_W-1] ? '0 : eng_rdata;

  // ReLU backward spends a second EXEC cycle reading the source word
  assign bw_src_read = state == EXEC && job.op == OP_RELU_BW && !src_phase;
  assign elem_done   = state == EXEC && !bw_src_read;
  assign finish      = state == FINAL || (elem_done && last && job.op != OP_BIAS_GRAD);

  always_comb begin
    eng_req_valid = 1'b0;
    eng_req.we    = 1'b0;
    eng_req.addr  = job.src_base + ofs;
    eng_req.wdata = relu_out;
    case (state)
      FETCH: begin
        eng_req_valid = 1'b1;
        if (job.op == OP_RELU_BW) begin
          eng_req.addr = job.aux_base + ofs;
        end
      end
      EXEC: begin
        if (bw_src_read) begin
          eng_req_valid = 1'b1;
        end else if (job.op == OP_RELU_FW || job.op == OP_RELU_BW) begin
          eng_req_valid = 1'b1;
          eng_req.we    = 1'b1;
          eng_req.addr  = job.dst_base + ofs;
          if (job.op == OP_RELU_BW) begin
            eng_req.wdata = aux_pos ? eng_rdata : '0;
          end
        end
      end
      FINAL: begin
        // Bias sum lands in a single word
        if (job.op == OP_BIAS_GRAD) begin
          eng_req_valid = 1'b1;
          eng_req.we    = 1'b1;
          eng_req.addr  = job.dst_base;
          eng_req.wdata = acc;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      state      <= IDLE;
      idx        <= '0;
      src_phase  <= 1'b0;
      job_done   <= 1'b0;
      done_count <= '0;
    end else begin
      job_done <= finish;
      if (finish) begin
        done_count <= done_count + 1'b1;
      end
      case (state)
        IDLE: begin
          if (pop_valid) begin
            idx       <= '0;
            src_phase <= 1'b0;
            state     <= (pop_job.len == '0) ? FINAL : FETCH;
          end
        end
        FETCH: state <= EXEC;
        EXEC: begin
          if (bw_src_read) begin
            src_phase <= 1'b1;
          end else begin
            src_phase <= 1'b0;
            idx       <= idx_next;
            if (!last) begin
              state <= FETCH;
            end else if (job.op == OP_BIAS_GRAD) begin
              state <= FINAL;
            end else begin
              state <= IDLE;
            end
          end
        end
        FINAL: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop_valid && pop_ready) begin
      job <= pop_job;
      acc <= '0;
    end
    if (bw_src_read) begin
      // Gradient passes only where the forward input was positive
      aux_pos <= !eng_rdata[`NN_DATA_W-1] && |eng_rdata;
    end
    if (elem_done && job.op == OP_BIAS_GRAD) begin
      acc <= acc + eng_rdata;
    end
  end

endmodule

`default_nettype wire

/* src/scratchpad.sv */
`default_nettype none
`timescale 1ns/1ps

`include "nn_settings.svh"

module scratchpad (
  input  wire logic             clk,
  input  wire nn_pkg::mem_req_t host_req,
  input  wire logic             host_req_valid,
  input  wire nn_pkg::mem_req_t eng_req,
  input  wire logic             eng_req_valid,
  output logic [`NN_DATA_W-1:0] host_rdata,
  output logic [`NN_DATA_W-1:0] eng_rdata
);

  localparam int WORDS = 1 << `NN_ADDR_W;

  logic [`NN_DATA_W-1:0] mem [WORDS];
  logic                  host_wr;
  logic                  eng_wr;

  // Engine wins a same-word write collision
  assign eng_wr  = eng_req_valid && eng_req.we;
  assign host_wr = host_req_valid && host_req.we &&
                   !(eng_wr && eng_req.addr == host_req.addr);

  always_ff @(posedge clk) begin
    if (host_wr) begin
      mem[host_req.addr] <= host_req.wdata;
    end
    if (eng_wr) begin
      mem[eng_req.addr] <= eng_req.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (host_req_valid && !host_req.we) begin
      host_rdata <= mem[host_req.addr];
    end
    if (eng_req_valid && !eng_req.we) begin
      eng_rdata <= mem[eng_req.addr];
    end
  end

endmodule

`default_nettype wire

/* src/job_queue.sv */
`default_nettype none
`timescale 1ns/1ps

`include "nn_settings.svh"

module job_queue (
  input  wire logic         clk,
  input  wire logic         rst_l,
  input  wire logic         push_valid,
  input  wire nn_pkg::job_t push_job,
  input  wire logic         pop_ready,
  output logic              push_ready,
  output logic              pop_valid,
  output nn_pkg::job_t      pop_job,
  output logic              full,
  output logic              empty
);
  import nn_pkg::*;

  localparam int PTR_W = (`NN_JOB_DEPTH > 1) ? $clog2(`NN_JOB_DEPTH) : 1;
  localparam int CNT_W = $clog2(`NN_JOB_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`NN_JOB_DEPTH - 1);

  job_t             slots [`NN_JOB_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full       = count == CNT_W'(`NN_JOB_DEPTH);
  assign empty      = count == '0;
  assign push_ready = !full;
  assign pop_valid  = !empty;
  assign pop_job    = slots[rd_ptr];
  assign do_push    = push_valid && push_ready;
  assign do_pop     = pop_valid && pop_ready;

  always_ff @(posedge clk) begin
    if (do_push) begin
      slots[wr_ptr] <= push_job;
    end
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end
      // Count only moves when one side is active alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/apb_job_port.sv */
`default_nettype none
`timescale 1ns/1ps

`include "nn_settings.svh"

module apb_job_port (
  input  wire logic                      clk,
  input  wire logic                      rst_l,
  input  wire logic                      psel,
  input  wire logic                      penable,
  input  wire logic                      pwrite,
  input  wire logic [`NN_APB_ADDR_W-1:0] paddr,
  input  wire logic [`NN_DATA_W-1:0]     pwdata,
  output logic      [`NN_DATA_W-1:0]     prdata,
  output logic                           pready,
  output logic                           pslverr,
  output logic                           push_valid,
  output nn_pkg::job_t                   push_job,
  input  wire logic                      push_ready,
  input  wire logic                      queue_full,
  input  wire logic [15:0]               done_count,
  output nn_pkg::mem_req_t               host_req,
  output logic                           host_req_valid,
  input  wire logic [`NN_DATA_W-1:0]     host_rdata
);
  import nn_pkg::*;

  // Word index of each register, byte address bits 4:2
  localparam logic [2:0] REG_SRC    = 3'd0;
  localparam logic [2:0] REG_AUX    = 3'd1;
  localparam logic [2:0] REG_DST    = 3'd2;
  localparam logic [2:0] REG_LEN    = 3'd3;
  localparam logic [2:0] REG_OP     = 3'd4;
  localparam logic [2:0] REG_STATUS = 3'd5;

  logic                  access;
  logic                  is_mem;
  logic                  rd_wait;
  logic                  op_write;
  logic                  op_legal;
  logic [2:0]            reg_idx;
  op_e                   op_req;
  logic [`NN_ADDR_W-1:0] src_q;
  logic [`NN_ADDR_W-1:0] aux_q;
  logic [`NN_ADDR_W-1:0] dst_q;
  logic [`NN_LEN_W-1:0]  len_q;

  assign access  = psel && penable;
  assign is_mem  = paddr[`NN_APB_ADDR_W-1];
  assign reg_idx = paddr[4:2];
  assign op_req  = op_e'(pwdata[2:0]);

  always_comb begin
    case (op_req)
      OP_RELU_FW, OP_RELU_BW, OP_BIAS_GRAD: op_legal = 1'b1;
      default: op_legal = 1'b0;
    endcase
  end

  // Launch on OP write, refused when full or opcode unknown
  assign op_write   = access && pwrite && !is_mem && reg_idx == REG_OP;
  assign push_valid = op_write && op_legal;
  assign pslverr    = op_write && (!op_legal || !push_ready);
  assign push_job   = '{op: op_req, src_base: src_q, aux_base: aux_q,
                        dst_base: dst_q, len: len_q};

  // Scratchpad reads issue in the first access cycle, data back in the second
  assign host_req       = '{we: pwrite, addr: paddr[`NN_ADDR_W+1:2], wdata: pwdata};
  assign host_req_valid = access && is_mem && (pwrite || !rd_wait);
  assign pready         = !(access && is_mem && !pwrite && !rd_wait);

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      rd_wait <= 1'b0;
    end else begin
      rd_wait <= access && is_mem && !pwrite && !rd_wait;
    end
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      src_q <= '0;
      aux_q <= '0;
      dst_q <= '0;
      len_q <= '0;
    end else if (access && pwrite && !is_mem) begin
      case (reg_idx)
        REG_SRC: src_q <= pwdata[`NN_ADDR_W-1:0];
        REG_AUX: aux_q <= pwdata[`NN_ADDR_W-1:0];
        REG_DST: dst_q <= pwdata[`NN_ADDR_W-1:0];
        REG_LEN: len_q <= pwdata[`NN_LEN_W-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    prdata = '0;
    if (is_mem) begin
      prdata = host_rdata;
    end else begin
      case (reg_idx)
        REG_SRC:    prdata[`NN_ADDR_W-1:0] = src_q;
        REG_AUX:    prdata[`NN_ADDR_W-1:0] = aux_q;
        REG_DST:    prdata[`NN_ADDR_W-1:0] = dst_q;
        REG_LEN:    prdata[`NN_LEN_W-1:0] = len_q;
        REG_STATUS: prdata = {{(`NN_DATA_W-17){1'b0}}, queue_full, done_count};
        default:    prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/nn_pkg.sv */
`default_nettype none

`include "nn_settings.svh"

package nn_pkg;

  typedef enum logic [2:0] {
    OP_RELU_FW   = 3'd1,
    OP_RELU_BW   = 3'd2,
    OP_BIAS_GRAD = 3'd3
  } op_e;

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    EXEC,
    FINAL
  } eng_state_e;

  // One launched job as it travels from the APB port to the engine
  typedef struct packed {
    op_e                   op;
    logic [`NN_ADDR_W-1:0] src_base;
    logic [`NN_ADDR_W-1:0] aux_base;
    logic [`NN_ADDR_W-1:0] dst_base;
    logic [`NN_LEN_W-1:0]  len;
  } job_t;

  // Single scratchpad port request
  typedef struct packed {
    logic                  we;
    logic [`NN_ADDR_W-1:0] addr;
    logic [`NN_DATA_W-1:0] wdata;
  } mem_req_t;

endpackage

`default_nettype wire

/* src/nn_settings.svh */
`ifndef NN_SETTINGS_SVH
`define NN_SETTINGS_SVH

// Scratchpad word and address widths
`define NN_DATA_W 32
`define NN_ADDR_W 8

// Job length counts 0 to 256 elements
`define NN_LEN_W 9

// Jobs waiting beside the one in the engine
`define NN_JOB_DEPTH 4

`define NN_APB_ADDR_W 12

`endif
